//--- Makefile
TOP := tb_top

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- alu_lane.sv
// One execution lane: issue queue, registered ALU, result queue
// Minimum latency from issue to result valid is three cycles
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module alu_lane
  import ooo_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  issue_pkt_t  in_pkt,
  output logic        out_valid,
  input  logic        out_ready,
  output result_pkt_t out_pkt
);

  logic        iq_valid;
  logic        iq_ready;
  issue_pkt_t  iq_pkt;
  result_pkt_t alu_next;   // Combinational ALU result
  logic        alu_valid;
  result_pkt_t alu_pkt;
  logic        rq_ready;

  lane_fifo #(.T(issue_pkt_t), .DEPTH(`OOO_FIFO_DEPTH)) u_issue_q (
    .clock      (clock),
    .arst_n     (arst_n),
    .push_valid (in_valid),
    .push_ready (in_ready),
    .push_data  (in_pkt),
    .pop_valid  (iq_valid),
    .pop_ready  (iq_ready),
    .pop_data   (iq_pkt)
  );

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    alu_next.dest  = iq_pkt.dest;
    alu_next.halt  = 1'b0;
    alu_next.value = '0;
    case (iq_pkt.op)
      ALU_ADD:  alu_next.value = iq_pkt.opa + iq_pkt.opb;   // Wraps modulo 2^32
      ALU_SUB:  alu_next.value = iq_pkt.opa - iq_pkt.opb;
      ALU_AND:  alu_next.value = iq_pkt.opa & iq_pkt.opb;
      ALU_OR:   alu_next.value = iq_pkt.opa | iq_pkt.opb;
      ALU_XOR:  alu_next.value = iq_pkt.opa ^ iq_pkt.opb;
      ALU_SLL:  alu_next.value = iq_pkt.opa << iq_pkt.opb[4:0];
      ALU_SRL:  alu_next.value = iq_pkt.opa >> iq_pkt.opb[4:0];
      ALU_SLTU: alu_next.value = data_t'(iq_pkt.opa < iq_pkt.opb);
      ALU_HALT: alu_next.halt  = 1'b1;
      default:  alu_next.value = '0;
    endcase
  end

  // Stage loads when empty or when its content moves on
  assign iq_ready = !alu_valid || rq_ready;

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      alu_valid <= 1'b0;
    else if (iq_ready)
      alu_valid <= iq_valid;
  end

  always_ff @(posedge clock)
  begin
    if (iq_ready && iq_valid)
      alu_pkt <= alu_next;
  end

  lane_fifo #(.T(result_pkt_t), .DEPTH(`OOO_FIFO_DEPTH)) u_result_q (
    .clock      (clock),
    .arst_n     (arst_n),
    .push_valid (alu_valid),
    .push_ready (rq_ready),
    .push_data  (alu_pkt),
    .pop_valid  (out_valid),
    .pop_ready  (out_ready),
    .pop_data   (out_pkt)
  );

endmodule

//--- flist.f
+incdir+.
ooo_pkg.sv
lane_fifo.sv
issue_dispatch.sv
alu_lane.sv
retire_unit.sv
ooo_exec_top.sv
tb_checker.sv
tb_top.sv

//--- issue_dispatch.sv
// Deals accepted instructions into the ALU lanes in strict rotation
// Lane order is program order, so the retire side can follow it back
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module issue_dispatch
  import ooo_pkg::*;
(
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  alu_op_e                   in_op,
  input  data_t                     in_opa,
  input  data_t                     in_opb,
  input  tag_t                      in_dest,
  output logic [`OOO_NUM_LANES-1:0] lane_in_valid,
  input  logic [`OOO_NUM_LANES-1:0] lane_in_ready,
  output issue_pkt_t                lane_in_pkt
);

  localparam int LANE_W = (`OOO_NUM_LANES > 1) ? $clog2(`OOO_NUM_LANES) : 1;

  logic [LANE_W-1:0] ptr;   // Lane that takes the next instruction
  logic              in_fire;

  // Same packet goes to every lane, only one sees valid
  assign lane_in_pkt = '{op: in_op, opa: in_opa, opb: in_opb, dest: in_dest};

  assign in_ready = lane_in_ready[ptr];
  assign in_fire  = in_valid && in_ready;

  always_comb
  begin
    for (int k = 0; k < `OOO_NUM_LANES; k++)
      lane_in_valid[k] = in_valid && (ptr == LANE_W'(k));
  end

  //////////////////////////////////////////////////////////////////////
  // Round-robin pointer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      ptr <= '0;
    else if (in_fire)
    begin
      if (ptr == LANE_W'(`OOO_NUM_LANES - 1))
        ptr <= '0;
      else
        ptr <= ptr + 1'b1;  // Move on only after a real transfer
    end
  end

endmodule

//--- lane_fifo.sv
// Circular valid/ready queue with a generic payload type
// Holds issue packets before the ALU and result packets after it
`timescale 1ns/1ps

module lane_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 2
) (
  input  logic clock,
  input  logic arst_n,
  input  logic push_valid,
  output logic push_ready,
  input  T     push_data,
  output logic pop_valid,
  input  logic pop_ready,
  output T     pop_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push_fire;
  logic             pop_fire;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full       = (count == CNT_W'(DEPTH));
  assign pop_valid  = (count != '0);
  assign pop_data   = mem[rd_ptr];
  assign push_ready = !full || pop_ready;  // A pop frees a slot this cycle
  assign push_fire  = push_valid && push_ready;
  assign pop_fire   = pop_valid && pop_ready;

  // Storage
  always_ff @(posedge clock)
  begin
    if (push_fire)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_fire)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop_fire)
        rd_ptr <= next_ptr(rd_ptr);
      case ({push_fire, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // Idle or push with pop
      endcase
    end
  end

endmodule

//--- ooo_cfg.svh
// Build-time widths and sizes for the issue/execute/retire slice
// Included by the package, the RTL modules and the testbench
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////
`define OOO_DATA_W      32  // Operand and result width
`define OOO_TAG_W       6   // Physical destination tag

//////////////////////////////////////////////////////////////////////
// Execution resources
//////////////////////////////////////////////////////////////////////
`define OOO_NUM_LANES   4   // ALU lanes, dealt round-robin
`define OOO_FIFO_DEPTH  2   // Entries per lane queue

// Writes to this physical register never reach the commit port
`define OOO_ZERO_TAG    0

`endif

//--- ooo_exec_top.sv
// Top of the slice: dispatcher, replicated ALU lanes, retire unit
// Instruction fields go in on the issue port, results leave in order
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module ooo_exec_top
  import ooo_pkg::*;
(
  input  logic        clock,
  input  logic        arst_n,
  input  logic        in_valid,
  output logic        in_ready,
  input  alu_op_e     in_op,
  input  data_t       in_opa,
  input  data_t       in_opb,
  input  tag_t        in_dest,
  output logic        commit_valid,
  output tag_t        commit_tag,
  output data_t       commit_data,
  output logic        commit_wr_en,
  input  logic        commit_ready,
  output logic [15:0] retired_count,
  output logic        halted
);

  logic [`OOO_NUM_LANES-1:0] lane_in_valid;
  logic [`OOO_NUM_LANES-1:0] lane_in_ready;
  issue_pkt_t                lane_in_pkt;     // Shared by all lanes
  logic [`OOO_NUM_LANES-1:0] lane_out_valid;
  logic [`OOO_NUM_LANES-1:0] lane_out_ready;
  result_pkt_t               lane_out_pkt [`OOO_NUM_LANES];

  issue_dispatch u_dispatch (
    .clock         (clock),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_opa        (in_opa),
    .in_opb        (in_opb),
    .in_dest       (in_dest),
    .lane_in_valid (lane_in_valid),
    .lane_in_ready (lane_in_ready),
    .lane_in_pkt   (lane_in_pkt)
  );

  for (genvar g = 0; g < `OOO_NUM_LANES; g++)
  begin : g_lane
    alu_lane u_lane (
      .clock     (clock),
      .arst_n    (arst_n),
      .in_valid  (lane_in_valid[g]),
      .in_ready  (lane_in_ready[g]),
      .in_pkt    (lane_in_pkt),
      .out_valid (lane_out_valid[g]),
      .out_ready (lane_out_ready[g]),
      .out_pkt   (lane_out_pkt[g])
    );
  end

  retire_unit u_retire (
    .clock          (clock),
    .arst_n         (arst_n),
    .lane_out_valid (lane_out_valid),
    .lane_out_ready (lane_out_ready),
    .lane_out_pkt   (lane_out_pkt),
    .commit_valid   (commit_valid),
    .commit_tag     (commit_tag),
    .commit_data    (commit_data),
    .commit_wr_en   (commit_wr_en),
    .commit_ready   (commit_ready),
    .retired_count  (retired_count),
    .halted         (halted)
  );

endmodule

//--- ooo_pkg.sv
// Operation codes and packet types shared by every stage
// Import with ooo_pkg::* in the module header
`include "ooo_cfg.svh"

package ooo_pkg;

  typedef logic [`OOO_DATA_W-1:0] data_t;
  typedef logic [`OOO_TAG_W-1:0]  tag_t;

  // ALU operation code carried with each instruction
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SLTU = 4'd7,
    ALU_HALT = 4'd8   // Retires with no write
  } alu_op_e;

  // Decoded instruction as it enters a lane, 74 bits
  typedef struct packed {
    alu_op_e op;
    data_t   opa;
    data_t   opb;
    tag_t    dest;
  } issue_pkt_t;

  // Lane result waiting for retirement, 39 bits
  typedef struct packed {
    tag_t  dest;
    data_t value;
    logic  halt;   // Set only by ALU_HALT
  } result_pkt_t;

endpackage

//--- retire_unit.sv
// Drains the lanes in dispatch order and drives the commit port
// Also keeps the retired instruction count and the halt status
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module retire_unit
  import ooo_pkg::*;
(
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic [`OOO_NUM_LANES-1:0] lane_out_valid,
  output logic [`OOO_NUM_LANES-1:0] lane_out_ready,
  input  result_pkt_t               lane_out_pkt [`OOO_NUM_LANES],
  output logic                      commit_valid,
  output tag_t                      commit_tag,
  output data_t                     commit_data,
  output logic                      commit_wr_en,
  input  logic                      commit_ready,
  output logic [15:0]               retired_count,
  output logic                      halted
);

  localparam int LANE_W = (`OOO_NUM_LANES > 1) ? $clog2(`OOO_NUM_LANES) : 1;

  logic [LANE_W-1:0] ptr;   // Lane holding the oldest instruction
  result_pkt_t       head;
  logic              commit_fire;

  assign head         = lane_out_pkt[ptr];
  assign commit_valid = lane_out_valid[ptr];
  assign commit_tag   = head.dest;
  assign commit_data  = head.value;
  assign commit_fire  = commit_valid && commit_ready;

  // No register write for the zero tag or a halt
  assign commit_wr_en = commit_valid && !head.halt &&
                        (head.dest != tag_t'(`OOO_ZERO_TAG));

  always_comb
  begin
    for (int k = 0; k < `OOO_NUM_LANES; k++)
      lane_out_ready[k] = commit_ready && (ptr == LANE_W'(k));
  end

  //////////////////////////////////////////////////////////////////////
  // Pointer, count and halt status
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ptr           <= '0;
      retired_count <= '0;
      halted        <= 1'b0;
    end
    else if (commit_fire)
    begin
      if (ptr == LANE_W'(`OOO_NUM_LANES - 1))
        ptr <= '0;
      else
        ptr <= ptr + 1'b1;
      retired_count <= retired_count + 1'b1;
      if (head.halt)
        halted <= 1'b1;   // Sticky until reset
    end
  end

endmodule

//--- tb_checker.sv
// Commit port monitor for the execution slice testbench
// Compares every commit with the expected table and keeps the error count
`timescale 1ns/1ps

module tb_checker
  import ooo_pkg::*;
#(
  parameter int NUM_TESTS = 40
) (
  input  logic             clock,
  input  logic             arst_n,
  input  logic             in_valid,
  input  logic             in_ready,
  input  logic             commit_valid,
  input  logic             commit_ready,
  input  tag_t             commit_tag,
  input  data_t            commit_data,
  input  logic             commit_wr_en,
  input  logic [15:0]      retired_count,
  input  logic             halted,
  input  logic             end_of_test,
  input  logic [8*12-1:0]  exp_name [NUM_TESTS],
  input  tag_t             exp_tag [NUM_TESTS],
  input  data_t            exp_data [NUM_TESTS],
  input  logic             exp_wr_en [NUM_TESTS],
  input  logic             exp_halt [NUM_TESTS],
  output int               commit_count,
  output int               error_count,
  output logic             all_committed,
  output logic             report_ready
);

  logic halt_seen;    // A halt has committed
  logic seen_issue;   // First instruction accepted

  initial
  begin
    commit_count = 0;
    error_count  = 0;
    report_ready = 1'b0;
    halt_seen    = 1'b0;
    seen_issue   = 1'b0;
  end

  assign all_committed = (commit_count == NUM_TESTS);

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  // Outputs of an empty pipeline right after reset
  task automatic check_idle();
    check_value("reset_idle", "commit_valid", 32'd0, 32'(commit_valid));
    check_value("reset_idle", "commit_wr_en", 32'd0, 32'(commit_wr_en));
    check_value("reset_idle", "halted", 32'd0, 32'(halted));
    check_value("reset_idle", "retired_count", 32'd0, 32'(retired_count));
    check_value("reset_idle", "in_ready", 32'd1, 32'(in_ready));
  endtask

  task automatic check_commit();
    string name;
    if (commit_count >= NUM_TESTS)
    begin
      $display("Extra commit with tag %0d after all %0d instructions had retired",
               commit_tag, NUM_TESTS);
      error_count++;
    end
    else
    begin
      name = string'(exp_name[commit_count]);
      check_value(name, "tag", 32'(exp_tag[commit_count]), 32'(commit_tag));
      check_value(name, "data", exp_data[commit_count], commit_data);
      check_value(name, "wr_en", 32'(exp_wr_en[commit_count]), 32'(commit_wr_en));
      if (exp_halt[commit_count])
        halt_seen = 1'b1;
      commit_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling at the rising edge where transfers happen
  //////////////////////////////////////////////////////////////////////
  always @(posedge clock)
  begin
    if (arst_n && !report_ready)
    begin
      if (!seen_issue)
        check_idle();
      check_value("halt_status", "halted", 32'(halt_seen), 32'(halted));  // Before this commit
      if (commit_valid && commit_ready)
        check_commit();
      if (in_valid && in_ready)
        seen_issue = 1'b1;
      if (end_of_test)
      begin
        check_value("final", "retired_count", NUM_TESTS, 32'(retired_count));
        check_value("final", "halted", 32'd1, 32'(halted));
        report_ready = 1'b1;
      end
    end
  end

endmodule

//--- tb_top.sv
// Testbench for the execution slice: clock, reset, instruction table
// Issues the table in order under random commit back-pressure
`timescale 1ns/1ps
`include "ooo_cfg.svh"

module tb_top
  import ooo_pkg::*;
;

  localparam int NUM_TESTS      = 40;
  localparam int TIMEOUT_CYCLES = 20 * NUM_TESTS + 200;

  logic        clock = 1'b0;
  logic        arst_n;
  logic        in_valid;
  logic        in_ready;
  alu_op_e     in_op;
  data_t       in_opa;
  data_t       in_opb;
  tag_t        in_dest;
  logic        commit_valid;
  tag_t        commit_tag;
  data_t       commit_data;
  logic        commit_wr_en;
  logic        commit_ready;
  logic [15:0] retired_count;
  logic        halted;

  // Instruction table and expected commit values
  logic [8*12-1:0] t_name [NUM_TESTS];
  alu_op_e         t_op [NUM_TESTS];
  data_t           t_opa [NUM_TESTS];
  data_t           t_opb [NUM_TESTS];
  tag_t            t_dest [NUM_TESTS];
  data_t           exp_data [NUM_TESTS];
  logic            exp_wr_en [NUM_TESTS];
  logic            exp_halt [NUM_TESTS];
  int              n_loaded = 0;

  logic   end_of_test;
  int     commit_count;
  int     error_count;
  logic   all_committed;
  logic   report_ready;
  int     cycle_count = 0;
  integer seed = 32'h56af3773;

  always #20 clock = ~clock;

  ooo_exec_top uut (
    .clock         (clock),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_opa        (in_opa),
    .in_opb        (in_opb),
    .in_dest       (in_dest),
    .commit_valid  (commit_valid),
    .commit_tag    (commit_tag),
    .commit_data   (commit_data),
    .commit_wr_en  (commit_wr_en),
    .commit_ready  (commit_ready),
    .retired_count (retired_count),
    .halted        (halted)
  );

  tb_checker #(.NUM_TESTS(NUM_TESTS)) chk (
    .clock         (clock),
    .arst_n        (arst_n),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .commit_valid  (commit_valid),
    .commit_ready  (commit_ready),
    .commit_tag    (commit_tag),
    .commit_data   (commit_data),
    .commit_wr_en  (commit_wr_en),
    .retired_count (retired_count),
    .halted        (halted),
    .end_of_test   (end_of_test),
    .exp_name      (t_name),
    .exp_tag       (t_dest),
    .exp_data      (exp_data),
    .exp_wr_en     (exp_wr_en),
    .exp_halt      (exp_halt),
    .commit_count  (commit_count),
    .error_count   (error_count),
    .all_committed (all_committed),
    .report_ready  (report_ready)
  );

  // Reference ALU behavior
  function automatic data_t alu_model(input alu_op_e op, input data_t a, input data_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[4:0];   // Only 5 bits of shift amount
      ALU_SRL:  return a >> b[4:0];
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:  return '0;
    endcase
  endfunction

  task automatic add_test(input logic [8*12-1:0] name, input alu_op_e op,
                          input data_t a, input data_t b, input tag_t dest);
    t_name[n_loaded]    = name;
    t_op[n_loaded]      = op;
    t_opa[n_loaded]     = a;
    t_opb[n_loaded]     = b;
    t_dest[n_loaded]    = dest;
    exp_data[n_loaded]  = alu_model(op, a, b);
    exp_wr_en[n_loaded] = (dest != tag_t'(`OOO_ZERO_TAG)) && (op != ALU_HALT);
    exp_halt[n_loaded]  = (op == ALU_HALT);
    n_loaded++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////
  task automatic load_table();
    add_test("add_basic",   ALU_ADD,  32'h00000005, 32'h00000007, 6'd1);
    add_test("add_wrap",    ALU_ADD,  32'hFFFFFFFF, 32'h00000001, 6'd2);
    add_test("add_max",     ALU_ADD,  32'h7FFFFFFF, 32'h00000001, 6'd3);
    add_test("add_zero_tag", ALU_ADD, 32'h12345678, 32'h00000001, 6'd0);
    add_test("sub_basic",   ALU_SUB,  32'h00000010, 32'h00000003, 6'd4);
    add_test("sub_wrap",    ALU_SUB,  32'h00000000, 32'h00000001, 6'd5);
    add_test("sub_self",    ALU_SUB,  32'hA5A5A5A5, 32'hA5A5A5A5, 6'd6);
    add_test("and_mask",    ALU_AND,  32'hF0F0F0F0, 32'h0FF00FF0, 6'd7);
    add_test("and_zero",    ALU_AND,  32'hFFFFFFFF, 32'h00000000, 6'd8);
    add_test("or_mix",      ALU_OR,   32'hF0000000, 32'h0000000F, 6'd9);
    add_test("or_ones",     ALU_OR,   32'hAAAAAAAA, 32'h55555555, 6'd10);
    add_test("xor_mix",     ALU_XOR,  32'hDEADBEEF, 32'hFFFFFFFF, 6'd11);
    add_test("xor_self",    ALU_XOR,  32'h13579BDF, 32'h13579BDF, 6'd0);
    add_test("sll_one",     ALU_SLL,  32'h00000001, 32'h00000001, 6'd12);
    add_test("sll_31",      ALU_SLL,  32'h00000001, 32'h0000001F, 6'd13);
    add_test("sll_wrapamt", ALU_SLL,  32'h00000003, 32'h00000021, 6'd14);
    add_test("sll_zero",    ALU_SLL,  32'hCAFEBABE, 32'h00000000, 6'd15);
    add_test("srl_one",     ALU_SRL,  32'h80000000, 32'h00000001, 6'd16);
    add_test("srl_31",      ALU_SRL,  32'h80000000, 32'h0000001F, 6'd17);
    add_test("srl_high",    ALU_SRL,  32'hFFFFFFFF, 32'hFFFFFFE4, 6'd18);
    add_test("sltu_lt",     ALU_SLTU, 32'h00000001, 32'h00000002, 6'd19);
    add_test("sltu_gt",     ALU_SLTU, 32'h00000002, 32'h00000001, 6'd20);
    add_test("sltu_eq",     ALU_SLTU, 32'h00000077, 32'h00000077, 6'd21);
    add_test("sltu_big",    ALU_SLTU, 32'h7FFFFFFF, 32'h80000000, 6'd22);
    add_test("sltu_zero",   ALU_SLTU, 32'h00000000, 32'hFFFFFFFF, 6'd0);
    add_test("add_mid",     ALU_ADD,  32'h00010000, 32'h0000FFFF, 6'd23);
    add_test("sub_neg",     ALU_SUB,  32'h00000005, 32'h0000000A, 6'd24);
    add_test("and_bits",    ALU_AND,  32'h12345678, 32'hF0F0F0F0, 6'd25);
    add_test("or_zero",     ALU_OR,   32'h00000000, 32'h00000000, 6'd26);
    add_test("xor_alt",     ALU_XOR,  32'h0F0F0F0F, 32'hF0F0F0F0, 6'd27);
    add_test("sll_byte",    ALU_SLL,  32'h000000FF, 32'h00000008, 6'd28);
    add_test("srl_byte",    ALU_SRL,  32'hFF000000, 32'h00000018, 6'd29);
    add_test("add_tag63",   ALU_ADD,  32'h11111111, 32'h22222222, 6'd63);
    add_test("sub_tag62",   ALU_SUB,  32'h33333333, 32'h11111111, 6'd62);
    add_test("sltu_max",    ALU_SLTU, 32'hFFFFFFFE, 32'hFFFFFFFF, 6'd30);
    add_test("or_tag0",     ALU_OR,   32'h00000001, 32'h00000002, 6'd0);
    add_test("xor_tag31",   ALU_XOR,  32'h89ABCDEF, 32'h76543210, 6'd31);
    add_test("srl_zero",    ALU_SRL,  32'h12345678, 32'h00000000, 6'd32);
    add_test("sll_16",      ALU_SLL,  32'hFFFFFFFF, 32'h00000010, 6'd33);
    add_test("halt_last",   ALU_HALT, 32'h00000000, 32'h00000000, 6'd34);  // Must stay last
  endtask

  // Random commit back-pressure, about half the cycles
  always @(posedge clock)
  begin
    #1;
    if (arst_n)
      commit_ready = $random(seed) & 1;
  end

  always @(posedge clock)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles with only %0d of %0d instructions committed",
               cycle_count, commit_count, NUM_TESTS);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_op        = ALU_ADD;
    in_opa       = '0;
    in_opb       = '0;
    in_dest      = '0;
    commit_ready = 1'b0;
    end_of_test  = 1'b0;
    load_table();
    repeat (8) @(posedge clock);
    #1;
    arst_n = 1'b1;
    for (int i = 0; i < NUM_TESTS; i++)
    begin
      in_valid = 1'b1;
      in_op    = t_op[i];
      in_opa   = t_opa[i];
      in_opb   = t_opb[i];
      in_dest  = t_dest[i];
      @(negedge clock);     // in_ready settled for this cycle
      while (!in_ready)
        @(negedge clock);
      @(posedge clock);
      #1;
    end
    in_valid = 1'b0;
    while (!all_committed)
    begin
      @(posedge clock);
      #1;
    end
    repeat (10) @(posedge clock);   // Room for a stray extra commit
    #1;
    end_of_test = 1'b1;
    while (!report_ready)
    begin
      @(posedge clock);
      #1;
    end
    $display("Run complete: %0d of %0d instructions committed, %0d errors",
             commit_count, NUM_TESTS, error_count);
    if (error_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
